// File: verilog/dac_consts.svh
// AD5601 DAC controller constants
// frame layout, serial clock divide, reset default and version word
`ifndef DAC_CONSTS_SVH
`define DAC_CONSTS_SVH

////////////////////////////////////////////////////////////
// frame layout
////////////////////////////////////////////////////////////

`define DAC_FRAME_W 16          // bits per serial frame
`define DAC_DATA_LSB 6          // data field sits in bits 13..6
`define DAC_DATA_W 8            // 8-bit DAC code
// bits 15..14 are the power mode (0 = normal), bits 5..0 are don't care zeros

////////////////////////////////////////////////////////////
// serial timing
////////////////////////////////////////////////////////////

`define DAC_SCLK_DIV 4          // system clocks per sclk period, must be even

////////////////////////////////////////////////////////////
// reset behaviour and identification
////////////////////////////////////////////////////////////

`define DAC_DEFAULT_FRAME 16'd100
`define DAC_WRITE_DEFAULT_ON_RESET 1   // 1 sends the default frame after reset

`define DAC_VERSION_ID 32'h0001_000a  // version 1, module id 10
`define DAC_ADDR_W 2                  // word address width of the register bus

`endif

// File: verilog/dac_pkg.sv
// AD5601 DAC controller shared types
// register bus structs, frame command and state encodings
`default_nettype none

`include "dac_consts.svh"

package dac_pkg;

    // register map, address 3 is unmapped and returns an error on read
    typedef enum logic [`DAC_ADDR_W-1:0] {
        REG_VERSION = 0,    // read only version word
        REG_DAC     = 1,    // 16-bit DAC frame register
        REG_CTRL    = 2     // read only control/status word
    } reg_addr_e;

    // register bus request, one access per strobe
    typedef struct packed {
        logic                   wr_stb;
        logic                   rd_stb;
        logic [`DAC_ADDR_W-1:0] addr;
        logic [31:0]            wdata;
    } reg_req_t;

    // read response, valid one cycle after the read strobe
    typedef struct packed {
        logic        rvalid;
        logic        err;
        logic [31:0] rdata;
    } reg_rsp_t;

    // frame command between stages
    typedef struct packed {
        logic                    start;   // one cycle strobe
        logic [`DAC_FRAME_W-1:0] frame;
    } dac_cmd_t;

    typedef enum logic [1:0] {
        SH_IDLE,
        SH_SHIFT,
        SH_GAP
    } shift_state_e;

endpackage

`default_nettype wire

// File: verilog/dac_reg_file.sv
// DAC register stage
// decodes register bus accesses, picks the write source and holds the DAC frame
`timescale 1ns/1ps
`default_nettype none

`include "dac_consts.svh"

module dac_reg_file (
    input  wire logic                   clk_ifc,
    input  wire logic                   SET_DEFAULT_ON_RESET,
    input  wire dac_pkg::reg_req_t      reg_req,
    input  wire logic                   en_avmm_ctrl,      // 1 = bus owns the frame
    input  wire logic [`DAC_DATA_W-1:0] dac_reg,
    input  wire logic                   dac_reg_valid,
    input  wire logic                   busy,
    output var  dac_pkg::reg_rsp_t      reg_rsp,
    output var  dac_pkg::dac_cmd_t      update
);

    logic                    bus_wr_dac;   // bus write to the frame register
    logic                    direct_wr;    // direct 8-bit update
    logic [`DAC_FRAME_W-1:0] frame_q;
    logic                    load_q;       // frame register changed last edge

    logic                    upd_start_q;
    logic [`DAC_FRAME_W-1:0] upd_frame_q;

    logic                    rvalid_q;
    logic                    err_q;
    logic [31:0]             rdata_q;
    logic [31:0]             rdata_mux;

    ////////////////////////////////////////////////////////////
    // write source select
    ////////////////////////////////////////////////////////////

    // the unselected source is simply dropped
    assign bus_wr_dac = reg_req.wr_stb && en_avmm_ctrl &&
                        (reg_req.addr == dac_pkg::REG_DAC);
    assign direct_wr  = dac_reg_valid && !en_avmm_ctrl;

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            frame_q     <= `DAC_DEFAULT_FRAME;
            load_q      <= 1'b0;
            upd_start_q <= 1'b0;
        end else begin
            load_q      <= bus_wr_dac || direct_wr;
            upd_start_q <= load_q;                    // update strobe trails the write by one
            if (bus_wr_dac) begin
                frame_q <= reg_req.wdata[`DAC_FRAME_W-1:0];
            end else if (direct_wr) begin
                frame_q[`DAC_DATA_LSB +: `DAC_DATA_W] <= dac_reg;  // power mode bits kept
            end
        end
    end

    always_ff @(posedge clk_ifc) begin
        upd_frame_q <= frame_q;
    end

    assign update.start = upd_start_q;
    assign update.frame = upd_frame_q;

    ////////////////////////////////////////////////////////////
    // read path
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (reg_req.addr)
            dac_pkg::REG_VERSION: rdata_mux = `DAC_VERSION_ID;
            dac_pkg::REG_DAC:     rdata_mux = {{(32-`DAC_FRAME_W){1'b0}}, frame_q};
            dac_pkg::REG_CTRL:    rdata_mux = {30'd0, busy, en_avmm_ctrl};
            default:              rdata_mux = 32'd0;    // unmapped
        endcase
    end

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            rvalid_q <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            rvalid_q <= reg_req.rd_stb;
            err_q    <= reg_req.rd_stb && (reg_req.addr == 2'd3);
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (reg_req.rd_stb) begin
            rdata_q <= rdata_mux;
        end
    end

    assign reg_rsp.rvalid = rvalid_q;
    assign reg_rsp.err    = err_q;
    assign reg_rsp.rdata  = rdata_q;

    // a response only ever answers the strobe one cycle before it
    a_no_spurious_rvalid : assert property (
        @(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        !reg_req.rd_stb |=> !reg_rsp.rvalid
    ) else $error("rvalid without a preceding read strobe");

endmodule

`default_nettype wire

// File: verilog/dac_cmd_sched.sv
// DAC command scheduler
// issues frames to an idle shifter and coalesces updates into one pending frame
`timescale 1ns/1ps
`default_nettype none

`include "dac_consts.svh"

module dac_cmd_sched (
    input  wire logic              clk_ifc,
    input  wire logic              SET_DEFAULT_ON_RESET,
    input  wire dac_pkg::dac_cmd_t update,
    input  wire logic              busy,
    input  wire logic              done,
    output var  dac_pkg::dac_cmd_t cmd,
    output var  logic              initdone
);

    logic                    free;         // shifter can take a start this cycle
    logic                    issue_new;
    logic                    issue_pend;
    logic                    pend_q;
    logic [`DAC_FRAME_W-1:0] pend_frame_q;
    logic                    start_q;
    logic [`DAC_FRAME_W-1:0] frame_q;

    // busy only rises the cycle after start, so an outstanding start counts too
    assign free = !busy && !start_q;

    // a fresh update always wins over the older pending frame
    assign issue_new  = update.start && free;
    assign issue_pend = pend_q && free && !update.start;

    ////////////////////////////////////////////////////////////
    // start and pending control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            start_q      <= 1'b0;
            pend_q       <= (`DAC_WRITE_DEFAULT_ON_RESET != 0);  // boot frame waits here
            pend_frame_q <= `DAC_DEFAULT_FRAME;
            initdone     <= 1'b0;
        end else begin
            start_q <= issue_new || issue_pend;
            pend_q  <= !free && (update.start || pend_q);
            if (update.start && !free) begin
                pend_frame_q <= update.frame;    // overwrite older pending value
            end
            // without a boot frame there is nothing to wait for
            if (done || (`DAC_WRITE_DEFAULT_ON_RESET == 0)) begin
                initdone <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (issue_new) begin
            frame_q <= update.frame;
        end else if (issue_pend) begin
            frame_q <= pend_frame_q;
        end
    end

    assign cmd.start = start_q;
    assign cmd.frame = frame_q;

    // shifter has no queue, a start into a busy shifter would be lost
    a_start_when_idle : assert property (
        @(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        cmd.start |-> !busy
    ) else $error("frame start issued while shifter busy");

    a_busy_follows_start : assert property (
        @(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        cmd.start |=> busy
    ) else $error("shifter did not pick up the frame start");

endmodule

`default_nettype wire

// File: verilog/dac_spi_shifter.sv
// DAC serial shifter
// sends one 16-bit frame MSB first on sclk/sync_n/mosi with a divided clock
`timescale 1ns/1ps
`default_nettype none

`include "dac_consts.svh"

module dac_spi_shifter (
    input  wire logic              clk_ifc,
    input  wire logic              SET_DEFAULT_ON_RESET,
    input  wire dac_pkg::dac_cmd_t cmd,
    output var  logic              busy,
    output var  logic              done,
    output var  logic              sclk,
    output var  logic              sync_n,
    output var  logic              mosi
);

    localparam int DIV_W = $clog2(`DAC_SCLK_DIV);
    localparam int BIT_W = $clog2(`DAC_FRAME_W);

    dac_pkg::shift_state_e   state;
    logic [DIV_W-1:0]        div_cnt;     // position inside one sclk period
    logic [BIT_W-1:0]        bit_cnt;     // bits already sent
    logic [`DAC_FRAME_W-1:0] shift_q;
    logic                    bit_end;     // last system clock of a bit
    logic                    load;

    assign bit_end = (div_cnt == DIV_W'(`DAC_SCLK_DIV - 1));
    assign load    = (state == dac_pkg::SH_IDLE) && cmd.start;
    assign busy    = (state != dac_pkg::SH_IDLE);

    ////////////////////////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////////////////////////

    // sclk is high for the first half of each bit, mosi moves as it rises
    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            state   <= dac_pkg::SH_IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
            sclk    <= 1'b0;
            sync_n  <= 1'b1;
            mosi    <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                dac_pkg::SH_IDLE: begin
                    if (cmd.start) begin
                        state   <= dac_pkg::SH_SHIFT;
                        sync_n  <= 1'b0;
                        sclk    <= 1'b1;
                        mosi    <= cmd.frame[`DAC_FRAME_W-1];
                        div_cnt <= '0;
                        bit_cnt <= '0;
                    end
                end
                dac_pkg::SH_SHIFT: begin
                    div_cnt <= div_cnt + 1'b1;
                    if (div_cnt == DIV_W'(`DAC_SCLK_DIV/2 - 1)) begin
                        sclk <= 1'b0;                      // falling edge, DAC samples here
                    end
                    if (bit_end) begin
                        div_cnt <= '0;
                        if (bit_cnt == BIT_W'(`DAC_FRAME_W - 1)) begin
                            state  <= dac_pkg::SH_GAP;
                            sync_n <= 1'b1;                // frame latched on rising sync_n
                            mosi   <= 1'b0;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            sclk    <= 1'b1;
                            mosi    <= shift_q[`DAC_FRAME_W-2];
                        end
                    end
                end
                dac_pkg::SH_GAP: begin
                    state <= dac_pkg::SH_IDLE;
                    done  <= 1'b1;                         // busy drops on the same edge
                end
                default: state <= dac_pkg::SH_IDLE;
            endcase
        end
    end

    // data shift register, MSB tracks the bit on mosi
    always_ff @(posedge clk_ifc) begin
        if (load) begin
            shift_q <= cmd.frame;
        end else if ((state == dac_pkg::SH_SHIFT) && bit_end) begin
            shift_q <= shift_q << 1;
        end
    end

    a_sync_low_in_shift : assert property (
        @(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        (state == dac_pkg::SH_SHIFT) |-> !sync_n
    ) else $error("sync_n high in the middle of a frame");

endmodule

`default_nettype wire

// File: verilog/dac_ad5601_ctrl.sv
// AD5601 DAC controller top level
// register stage, command scheduler and serial shifter in a chain
`timescale 1ns/1ps
`default_nettype none

`include "dac_consts.svh"

module dac_ad5601_ctrl (
    input  wire logic                   clk_ifc,
    input  wire logic                   SET_DEFAULT_ON_RESET,   // sync, active high
    input  wire dac_pkg::reg_req_t      reg_req,
    input  wire logic                   en_avmm_ctrl,
    input  wire logic [`DAC_DATA_W-1:0] dac_reg,
    input  wire logic                   dac_reg_valid,
    output var  dac_pkg::reg_rsp_t      reg_rsp,
    output var  logic                   sclk,
    output var  logic                   sync_n,
    output var  logic                   mosi,
    output var  logic                   dac_reg_updated,
    output var  logic                   initdone
);

    dac_pkg::dac_cmd_t update;   // register stage to scheduler
    dac_pkg::dac_cmd_t cmd;      // scheduler to shifter
    logic              busy;
    logic              done;

    dac_reg_file i_dac_reg_file (
        .clk_ifc              ( clk_ifc              ),
        .SET_DEFAULT_ON_RESET ( SET_DEFAULT_ON_RESET ),
        .reg_req              ( reg_req              ),
        .en_avmm_ctrl         ( en_avmm_ctrl         ),
        .dac_reg              ( dac_reg              ),
        .dac_reg_valid        ( dac_reg_valid        ),
        .busy                 ( busy                 ),
        .reg_rsp              ( reg_rsp              ),
        .update               ( update               )
    );

    dac_cmd_sched i_dac_cmd_sched (
        .clk_ifc              ( clk_ifc              ),
        .SET_DEFAULT_ON_RESET ( SET_DEFAULT_ON_RESET ),
        .update               ( update               ),
        .busy                 ( busy                 ),
        .done                 ( done                 ),
        .cmd                  ( cmd                  ),
        .initdone             ( initdone             )
    );

    dac_spi_shifter i_dac_spi_shifter (
        .clk_ifc              ( clk_ifc              ),
        .SET_DEFAULT_ON_RESET ( SET_DEFAULT_ON_RESET ),
        .cmd                  ( cmd                  ),
        .busy                 ( busy                 ),
        .done                 ( done                 ),
        .sclk                 ( sclk                 ),
        .sync_n               ( sync_n               ),
        .mosi                 ( mosi                 )
    );

    assign dac_reg_updated = done;   // one pulse per completed frame

endmodule

`default_nettype wire

// File: dv/dac_checker.sv
// DAC serial frame checker
// rebuilds frames from the serial pins and compares them with expected values
`timescale 1ns/1ps
`default_nettype none

`include "dac_consts.svh"

module dac_checker (
    input wire logic clk_ifc,
    input wire logic SET_DEFAULT_ON_RESET,
    input wire logic sclk,
    input wire logic sync_n,
    input wire logic mosi
);

    logic [`DAC_FRAME_W-1:0] exp_q[$];      // filled by the test sequence
    logic [`DAC_FRAME_W-1:0] shift;
    logic                    sclk_q;        // sclk seen at the previous edge
    int                      bit_cnt;
    int                      frames_seen = 0;
    int                      errors = 0;

    // expected frame after one accepted write
    function automatic logic [15:0] ref_frame(input logic [15:0] prior,
                                              input logic from_bus,
                                              input logic [31:0] value);
        if (from_bus) begin
            return value[15:0];                        // bus loads the whole frame
        end
        return {prior[15:14], value[7:0], prior[5:0]};  // direct path touches data only
    endfunction

    task automatic push_expect(input logic [15:0] frame);
        exp_q.push_back(frame);
    endtask

    function automatic int expect_left();
        return exp_q.size();
    endfunction

    task automatic check_frame(input logic [15:0] got);
        logic [15:0] exp;
        frames_seen++;
        if (exp_q.size() == 0) begin
            errors++;
            $display("frame %h came out at %0t with no frame expected", got, $time);
        end else begin
            exp = exp_q.pop_front();
            if (got !== exp) begin
                errors++;
                $display("MISMATCH at %0t: frame got %h expected %h", $time, got, exp);
            end
        end
    endtask

    // the DAC takes mosi on each falling sclk while sync_n is low
    always @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            bit_cnt <= 0;
            sclk_q  <= 1'b0;
        end else begin
            sclk_q <= sclk;
            if (sync_n) begin
                if (bit_cnt != 0 && bit_cnt != `DAC_FRAME_W) begin
                    errors++;
                    $display("frame cut short after %0d bits at %0t", bit_cnt, $time);
                end
                bit_cnt <= 0;
            end else if (sclk_q && !sclk) begin
                shift   <= {shift[`DAC_FRAME_W-2:0], mosi};
                bit_cnt <= bit_cnt + 1;
                if (bit_cnt == `DAC_FRAME_W - 1) begin
                    check_frame({shift[`DAC_FRAME_W-2:0], mosi});
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/dac_ad5601_ctrl_tb.sv
// AD5601 DAC controller testbench
// bus and direct writes, coalescing and register reads against a reference model
`timescale 1ns/1ps
`default_nettype none

`include "dac_consts.svh"

module dac_ad5601_ctrl_tb;

    logic                    clk_ifc = 1'b0;
    logic                    SET_DEFAULT_ON_RESET;
    dac_pkg::reg_req_t       reg_req;
    logic                    en_avmm_ctrl;
    logic [`DAC_DATA_W-1:0]  dac_reg;
    logic                    dac_reg_valid;
    dac_pkg::reg_rsp_t       reg_rsp;
    logic                    sclk;
    logic                    sync_n;
    logic                    mosi;
    logic                    dac_reg_updated;
    logic                    initdone;

    integer                  seed = 32'h5ab2_3d42;
    logic [`DAC_FRAME_W-1:0] model;        // frame the DAC should hold
    int                      exp_frames = 0;
    int                      tb_errors = 0;
    int                      tests_run = 0;
    int                      tests_failed = 0;
    int                      err_mark = 0;

    always #4 clk_ifc = ~clk_ifc;

    dac_ad5601_ctrl i_dac_ad5601_ctrl (
        .clk_ifc              ( clk_ifc              ),
        .SET_DEFAULT_ON_RESET ( SET_DEFAULT_ON_RESET ),
        .reg_req              ( reg_req              ),
        .en_avmm_ctrl         ( en_avmm_ctrl         ),
        .dac_reg              ( dac_reg              ),
        .dac_reg_valid        ( dac_reg_valid        ),
        .reg_rsp              ( reg_rsp              ),
        .sclk                 ( sclk                 ),
        .sync_n               ( sync_n               ),
        .mosi                 ( mosi                 ),
        .dac_reg_updated      ( dac_reg_updated      ),
        .initdone             ( initdone             )
    );

    dac_checker i_dac_checker (
        .clk_ifc              ( clk_ifc              ),
        .SET_DEFAULT_ON_RESET ( SET_DEFAULT_ON_RESET ),
        .sclk                 ( sclk                 ),
        .sync_n               ( sync_n               ),
        .mosi                 ( mosi                 )
    );

    ////////////////////////////////////////////////////////////
    // helpers that drive stimulus on the falling edge
    ////////////////////////////////////////////////////////////

    function automatic int total_errors();
        return tb_errors + i_dac_checker.errors;
    endfunction

    task automatic fail_note(input string msg);
        tb_errors++;
        $display("%s at %0t", msg, $time);
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            tb_errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic bus_write(input logic [1:0] addr, input logic [31:0] data);
        @(negedge clk_ifc);
        reg_req.wr_stb = 1'b1;
        reg_req.addr   = addr;
        reg_req.wdata  = data;
        @(negedge clk_ifc);
        reg_req.wr_stb = 1'b0;
    endtask

    task automatic bus_read(input logic [1:0] addr, output logic [31:0] data,
                            output logic err);
        @(negedge clk_ifc);
        reg_req.rd_stb = 1'b1;
        reg_req.addr   = addr;
        @(negedge clk_ifc);
        reg_req.rd_stb = 1'b0;
        if (!reg_rsp.rvalid) begin
            fail_note("no read response one cycle after the read strobe");
        end
        data = reg_rsp.rdata;
        err  = reg_rsp.err;
    endtask

    task automatic direct_write(input logic [`DAC_DATA_W-1:0] value);
        @(negedge clk_ifc);
        dac_reg       = value;
        dac_reg_valid = 1'b1;
        @(negedge clk_ifc);
        dac_reg_valid = 1'b0;
    endtask

    // steps one cycle past the pulse so it is not counted twice
    task automatic wait_updated(input string what);
        int n;
        n = 0;
        while (!dac_reg_updated && n < 300) begin
            @(negedge clk_ifc);
            n++;
        end
        if (!dac_reg_updated) begin
            fail_note({"timed out waiting for dac_reg_updated after ", what});
        end else begin
            @(negedge clk_ifc);
        end
    endtask

    task automatic wait_sync_low();
        int n;
        n = 0;
        while (sync_n && n < 20) begin
            @(negedge clk_ifc);
            n++;
        end
        if (sync_n) begin
            fail_note("timed out waiting for sync_n to fall");
        end
    endtask

    task automatic quiet_window(input int cycles, input string what);
        repeat (cycles) begin
            @(negedge clk_ifc);
            if (dac_reg_updated || !sync_n) begin
                fail_note({"a frame was sent ", what});
                return;
            end
        end
    endtask

    task automatic expect_model();
        i_dac_checker.push_expect(model);
        exp_frames++;
    endtask

    task automatic end_test(input string name);
        check_value(i_dac_checker.frames_seen, exp_frames, "frames sent so far");
        tests_run++;
        if (total_errors() != err_mark) begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end else begin
            $display("test %0d %s: passed", tests_run, name);
        end
        err_mark = total_errors();
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] rd;
        logic        err;
        logic [31:0] val;
        reg_req              = '0;
        en_avmm_ctrl         = 1'b1;
        dac_reg              = '0;
        dac_reg_valid        = 1'b0;
        SET_DEFAULT_ON_RESET = 1'b1;
        model                = `DAC_DEFAULT_FRAME;
        if (`DAC_WRITE_DEFAULT_ON_RESET != 0) begin
            expect_model();                       // boot frame
        end
        repeat (2) @(posedge clk_ifc);
        @(negedge clk_ifc);
        SET_DEFAULT_ON_RESET = 1'b0;
        check_value(initdone, 0, "initdone before the first frame");

        wait_updated("reset release");
        check_value(initdone, 1, "initdone after the first frame");
        end_test("reset default frame");

        for (int i = 0; i < 6; i++) begin
            val   = $random(seed);
            model = i_dac_checker.ref_frame(model, 1'b1, val);
            expect_model();
            bus_write(dac_pkg::REG_DAC, val);
            wait_updated("bus write");
            bus_read(dac_pkg::REG_DAC, rd, err);
            check_value(rd, {16'd0, model}, "REG_DAC readback");
        end
        end_test("bus writes");

        en_avmm_ctrl = 1'b0;
        for (int i = 0; i < 6; i++) begin
            val   = $random(seed);
            model = i_dac_checker.ref_frame(model, 1'b0, val);
            expect_model();
            direct_write(val[7:0]);
            wait_updated("direct strobe");
            bus_read(dac_pkg::REG_DAC, rd, err);
            check_value(rd, {16'd0, model}, "REG_DAC readback");
        end
        bus_write(dac_pkg::REG_DAC, $random(seed));   // bus not selected
        quiet_window(100, "after a bus write with the direct source selected");
        bus_read(dac_pkg::REG_DAC, rd, err);
        check_value(rd, {16'd0, model}, "REG_DAC readback after ignored write");
        end_test("direct strobes");

        en_avmm_ctrl = 1'b1;
        repeat (3) begin
            val = $random(seed);
            direct_write(val[7:0]);
        end
        quiet_window(100, "after direct strobes with the bus selected");
        end_test("ignored direct strobes");

        val   = $random(seed);
        model = i_dac_checker.ref_frame(model, 1'b1, val);
        expect_model();
        bus_write(dac_pkg::REG_DAC, val);
        wait_sync_low();
        bus_read(dac_pkg::REG_CTRL, rd, err);
        check_value(rd, 32'h3, "control word with a frame in flight");  // bus selected and busy
        repeat (3) begin
            val   = $random(seed);
            model = i_dac_checker.ref_frame(model, 1'b1, val);
            bus_write(dac_pkg::REG_DAC, val);
        end
        expect_model();                                // only the last one survives
        wait_updated("frame in flight");
        wait_updated("coalesced frame");
        quiet_window(100, "after the coalesced frame");
        end_test("coalesced writes");

        bus_read(dac_pkg::REG_VERSION, rd, err);
        check_value(rd, `DAC_VERSION_ID, "version word");
        check_value(err, 0, "error flag on version read");
        bus_read(dac_pkg::REG_CTRL, rd, err);
        check_value(rd, 32'h1, "control word");        // bus selected and shifter idle
        bus_read(2'd3, rd, err);
        check_value(err, 1, "error flag on unmapped address");
        end_test("register reads");

        if (i_dac_checker.expect_left() != 0) begin
            fail_note("expected frames never came out on the serial pins");
        end
        $display("tests run %0d, failed %0d, frames checked %0d, errors %0d",
                 tests_run, tests_failed, i_dac_checker.frames_seen, total_errors());
        if (total_errors() == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+verilog
verilog/dac_pkg.sv
verilog/dac_reg_file.sv
verilog/dac_cmd_sched.sv
verilog/dac_spi_shifter.sv
verilog/dac_ad5601_ctrl.sv
dv/dac_checker.sv
dv/dac_ad5601_ctrl_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= dac_ad5601_ctrl_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
